// File: verilog/hv_types_pkg.sv
package hv_types_pkg;

    // data path width, shared by items, accumulators and result words
    localparam int WORD_W = 32;

    // item memory address width
    localparam int INDEX_W = 9;

    // enough bits to rotate by any position inside a word
    localparam int ROT_W = $clog2(WORD_W);

    // item memory geometry, one entry per source index
    localparam int ITEM_DEPTH = 1 << INDEX_W;

    // lanes sharing one exec strobe, even lane first
    localparam int NUM_LANES = 2;

    // item values, accumulators and result words
    typedef logic [WORD_W-1:0] word_t;

    // source index into the item memory
    typedef logic [INDEX_W-1:0] index_t;

    // rotate amount, taken from the low bits of an item
    typedef logic [ROT_W-1:0] rot_t;

endpackage

// File: verilog/hv_timing_pkg.sv
package hv_timing_pkg;

    // edges from a sampled exec until the accumulator holds the fold
    // one edge each for item lookup, the stage register and the fold
    localparam int EXEC_LATENCY = 3;

    // edges from a sampled init until the accumulator is cleared
    // two edges, so a clear can overtake a fold still in the pipe
    localparam int INIT_LATENCY = 2;

    // readout FSM states
    // RD_EMPTY means nothing left to shift out
    typedef enum logic [1:0] {
        RD_EMPTY = 2'd0,
        RD_LANE0 = 2'd1,
        RD_LANE1 = 2'd2
    } readout_state_t;

endpackage

// File: verilog/bind_core.sv
`timescale 1ns/1ps

module bind_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 init,
    input  logic                 exec,
    input  hv_types_pkg::index_t src,
    output hv_types_pkg::word_t  acc
);
    import hv_types_pkg::*;
    import hv_timing_pkg::*;

    // item memory, entry i holds the value i
    word_t item_mem [ITEM_DEPTH];

    // delayed strobes, bit 0 is one edge after the sample
    logic [EXEC_LATENCY-1:0] exec_pipe;
    logic [INIT_LATENCY-1:0] init_pipe;

    // data path registers
    index_t src_q;
    word_t  item_q;
    word_t  stage_q;

    // fold operand
    rot_t  rot_amt;
    word_t rotated;

    // rotate right, amount is always below the word width
    function automatic word_t rotr(word_t value, rot_t amount);
        logic [2*WORD_W-1:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[WORD_W-1:0];
    endfunction

    initial begin
        for (int i = 0; i < ITEM_DEPTH; i++) begin
            item_mem[i] = word_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exec_pipe <= '0;
            init_pipe <= '0;
        end else begin
            exec_pipe <= {exec_pipe[EXEC_LATENCY-2:0], exec};
            init_pipe <= {init_pipe[INIT_LATENCY-2:0], init};
        end
    end

    // index is held with the strobe, lookup happens one edge later
    always_ff @(posedge clk) begin
        if (exec) begin
            src_q <= src;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_pipe[0]) begin
            item_q <= item_mem[src_q];
        end
    end

    // extra register between the memory read and the rotate/xor
    always_ff @(posedge clk) begin
        if (exec_pipe[1]) begin
            stage_q <= item_q;
        end
    end

    // rotate by the item's own low bits
    always_comb begin
        rot_amt = stage_q[ROT_W-1:0];
        rotated = rotr(stage_q, rot_amt);
    end

    // clear takes priority, a fold landing on the same edge is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (init_pipe[INIT_LATENCY-1]) begin
            acc <= '0;
        end else if (exec_pipe[EXEC_LATENCY-1]) begin
            acc <= acc ^ rotated;
        end
    end

    // init and exec are separate commands from the sequencer
    init_exec_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(init && exec)
    ) else $error("bind_core: init and exec asserted together");

    // accumulator only moves when a delayed strobe lands
    acc_hold_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        (!exec_pipe[EXEC_LATENCY-1] && !init_pipe[INIT_LATENCY-1]) |=> $stable(acc)
    ) else $error("bind_core: acc changed with no fold or clear due");

endmodule

// File: verilog/acc_readout.sv
`timescale 1ns/1ps

module acc_readout (
    input  logic                clk,
    input  logic                reset,
    input  logic                update,
    input  logic                out_period,
    input  hv_types_pkg::word_t acc_even,
    input  hv_types_pkg::word_t acc_odd,
    output hv_types_pkg::word_t result,
    output logic                result_valid
);
    import hv_types_pkg::*;
    import hv_timing_pkg::*;

    // snapshot of both lanes, index 0 is the even lane
    word_t capture [NUM_LANES];

    readout_state_t state;
    readout_state_t state_next;

    // both lanes captured on the same edge
    always_ff @(posedge clk) begin
        if (update) begin
            capture[0] <= acc_even;
            capture[1] <= acc_odd;
        end
    end

    // update restarts the readout, even in the middle of one
    always_comb begin
        state_next = state;
        if (update) begin
            state_next = RD_LANE0;
        end else if (out_period) begin
            case (state)
                RD_LANE0: state_next = RD_LANE1;
                RD_LANE1: state_next = RD_EMPTY;
                default:  state_next = RD_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RD_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // word selected by the current state
    always_comb begin
        case (state)
            RD_LANE0: result = capture[0];
            RD_LANE1: result = capture[1];
            default:  result = '0;
        endcase
    end

    assign result_valid = (state != RD_EMPTY);

    // nothing to read straight out of reset
    valid_low_after_reset: assert property (
        @(posedge clk)
        reset |=> !result_valid
    ) else $error("acc_readout: result_valid high after reset");

    // out_period alone never refills an empty readout
    empty_left_on_update: assert property (
        @(posedge clk) disable iff (reset)
        (state == RD_EMPTY && !update) |=> (state == RD_EMPTY)
    ) else $error("acc_readout: left RD_EMPTY without update");

endmodule

// File: verilog/hv_accum_top.sv
`timescale 1ns/1ps

module hv_accum_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 init,
    input  logic                 exec,
    input  logic                 update,
    input  logic                 out_period,
    input  hv_types_pkg::index_t src_even,
    input  hv_types_pkg::index_t src_odd,
    output hv_types_pkg::word_t  result,
    output logic                 result_valid
);
    import hv_types_pkg::*;

    // lane accumulators, even lane at index 0
    word_t lane_acc [NUM_LANES];

    // even source indices
    bind_core core_even (
        .clk   (clk),
        .reset (reset),
        .init  (init),
        .exec  (exec),
        .src   (src_even),
        .acc   (lane_acc[0])
    );

    // odd source indices, same exec strobe
    bind_core core_odd (
        .clk   (clk),
        .reset (reset),
        .init  (init),
        .exec  (exec),
        .src   (src_odd),
        .acc   (lane_acc[1])
    );

    // capture on update, shift out one word per out_period
    acc_readout readout (
        .clk          (clk),
        .reset        (reset),
        .update       (update),
        .out_period   (out_period),
        .acc_even     (lane_acc[0]),
        .acc_odd      (lane_acc[1]),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);
    // 20 ns period
    localparam time HALF_PERIOD = 10ns;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD);
        clk = ~clk;
    end

endmodule

// File: verif/hv_accum_tb.sv
`timescale 1ns/1ps

module hv_accum_tb;
    import hv_types_pkg::*;
    import hv_timing_pkg::*;

    localparam int VALID_TIMEOUT = 20;

    logic   clk;
    logic   reset;
    logic   init;
    logic   exec;
    logic   update;
    logic   out_period;
    index_t src_even;
    index_t src_odd;
    word_t  result;
    logic   result_valid;

    // model accumulators, index 0 is the even lane
    word_t  model_acc [NUM_LANES];
    integer seed;

    // shared with the compare process
    string  check_name;
    word_t  check_word;
    logic   check_armed;

    tb_clock_gen clock_gen (
        .clk (clk)
    );

    hv_accum_top hv_accum_top_i (
        .clk          (clk),
        .reset        (reset),
        .init         (init),
        .exec         (exec),
        .update       (update),
        .out_period   (out_period),
        .src_even     (src_even),
        .src_odd      (src_odd),
        .result       (result),
        .result_valid (result_valid)
    );

    // item i is the value i, rotated right by its low five bits
    function automatic word_t fold_item(word_t acc_in, index_t idx);
        word_t item;
        word_t turned;
        rot_t  amount;
        item = word_t'(idx);
        amount = rot_t'(idx % 32);
        if (amount == 0) begin
            turned = item;
        end else begin
            turned = (item >> amount) | (item << (32 - amount));
        end
        return acc_in ^ turned;
    endfunction

    // compare at the falling edge, well away from the drive edge
    always @(negedge clk) begin
        if (check_armed && result_valid) begin
            assert (result === check_word) else begin
                $display("Mismatch in %s: expected %h, actual %h",
                         check_name, check_word, result);
                $display("Test FAILED");
                $fatal(1, "result word wrong");
            end
            check_armed = 1'b0;
        end
    end

    task automatic expect_result(input string name, input word_t word);
        int waited;
        check_name = name;
        check_word = word;
        check_armed = 1'b1;
        waited = 0;
        while (check_armed) begin
            if (waited >= VALID_TIMEOUT) begin
                $display("result_valid never rose in %s", name);
                $display("Test FAILED");
                $fatal(1, "timeout waiting for result_valid");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic check_empty(input string name);
        @(negedge clk);
        assert (!result_valid) else begin
            $display("result_valid stayed high after the readout ran out in %s", name);
            $display("Test FAILED");
            $fatal(1, "readout did not empty");
        end
    endtask

    task automatic drive_exec(input index_t even_idx, input index_t odd_idx);
        @(posedge clk);
        exec <= 1'b1;
        src_even <= even_idx;
        src_odd <= odd_idx;
        model_acc[0] = fold_item(model_acc[0], even_idx);
        model_acc[1] = fold_item(model_acc[1], odd_idx);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            exec <= 1'b0;
        end
    endtask

    task automatic random_execs(input int count);
        repeat (count) begin
            drive_exec(index_t'($random(seed)), index_t'($random(seed)));
        end
        idle_cycles(EXEC_LATENCY + 1);
    endtask

    task automatic pulse_update();
        @(posedge clk);
        update <= 1'b1;
        @(posedge clk);
        update <= 1'b0;
    endtask

    task automatic pulse_out();
        @(posedge clk);
        out_period <= 1'b1;
        @(posedge clk);
        out_period <= 1'b0;
    endtask

    task automatic pulse_init();
        @(posedge clk);
        init <= 1'b1;
        @(posedge clk);
        init <= 1'b0;
        model_acc[0] = '0;
        model_acc[1] = '0;
        idle_cycles(INIT_LATENCY + 1);
    endtask

    // full readout: lane 0, lane 1, then empty
    task automatic read_both(input string name);
        pulse_update();
        expect_result({name, " lane 0"}, model_acc[0]);
        pulse_out();
        expect_result({name, " lane 1"}, model_acc[1]);
        pulse_out();
        check_empty(name);
    endtask

    initial begin
        seed = 32'h410d1347;
        check_armed = 1'b0;
        check_word = '0;
        check_name = "";
        model_acc[0] = '0;
        model_acc[1] = '0;
        reset <= 1'b1;
        init <= 1'b0;
        exec <= 1'b0;
        update <= 1'b0;
        out_period <= 1'b0;
        src_even <= '0;
        src_odd <= '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        check_empty("reset");

        // zero accumulators straight out of reset
        read_both("zero readout");

        // single exec, known indices
        drive_exec(index_t'(37), index_t'(100));
        idle_cycles(EXEC_LATENCY + 1);
        read_both("single exec");

        // every pipeline slot busy
        random_execs(40);
        read_both("exec burst");

        // clear, then accumulate again from zero
        pulse_init();
        read_both("after init");
        random_execs(5);
        read_both("init then execs");

        // out_period while empty is ignored
        pulse_out();
        check_empty("out while empty");

        // update in the middle of a readout restarts at lane 0
        random_execs(3);
        pulse_update();
        expect_result("restart first lane 0", model_acc[0]);
        pulse_out();
        expect_result("restart first lane 1", model_acc[1]);
        random_execs(2);
        pulse_update();
        expect_result("restart fresh lane 0", model_acc[0]);
        pulse_out();
        expect_result("restart fresh lane 1", model_acc[1]);
        pulse_out();
        check_empty("restart");

        $display("Test OK");
        $finish;
    end

endmodule

// File: sim.f
verilog/hv_types_pkg.sv
verilog/hv_timing_pkg.sv
verilog/bind_core.sv
verilog/acc_readout.sv
verilog/hv_accum_top.sv
verif/tb_clock_gen.sv
verif/hv_accum_tb.sv
